// ==== logic/lsu_iq_pkg.sv ====
package lsu_iq_pkg;

    localparam int prf_w = 6;

    // memory opcodes, stores in the upper half
    typedef enum logic [2:0] {
        op_lb,
        op_lh,
        op_lw,
        op_lbu,
        op_lhu,
        op_sb,
        op_sh,
        op_sw
    } mem_op_e;

    typedef logic [prf_w-1:0] prf_num_t;

    typedef struct packed {
        logic        valid;
        mem_op_e     op;
        prf_num_t    psrc0;    // base
        prf_num_t    psrc1;    // store data
        prf_num_t    pdest;
        logic [11:0] imm;
        logic [5:0]  rob_tag;
    } lsu_uop_t;

    typedef struct packed {
        logic rdy0;
        logic rdy1;
    } src_rdy_t;

    // one queue slot worth of state
    typedef struct packed {
        lsu_uop_t uop;
        src_rdy_t rdys;
    } lsu_iq_entry_t;

    function automatic logic is_store_op(input mem_op_e op);
        logic st;
        case (op)
            op_sb, op_sh, op_sw: st = 1'b1;
            default:             st = 1'b0;
        endcase
        return st;
    endfunction

endpackage

// ==== logic/lsu_iq_entry.sv ====
`timescale 1ns/1ns

module lsu_iq_entry import lsu_iq_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          flush,
    input  logic          load_en,
    input  logic          load_sel,
    input  logic          shift_en,
    input  lsu_iq_entry_t din0,
    input  lsu_iq_entry_t din1,
    input  lsu_iq_entry_t up,
    input  src_rdy_t      up_rdy_next,
    input  logic          busy0,
    input  logic          busy1,
    output lsu_iq_entry_t q,
    output src_rdy_t      rdy_next,
    output logic          is_store
);

    lsu_iq_entry_t enq_data;
    lsu_iq_entry_t next_data;

    // readiness only ever goes from 0 to 1 while held
    assign rdy_next.rdy0 = q.rdys.rdy0 | ~busy0;
    assign rdy_next.rdy1 = q.rdys.rdy1 | ~busy1;

    assign enq_data = load_sel ? din1 : din0;

    always_comb begin
        if (load_en) begin
            next_data = enq_data;     // lane readiness already merged
        end else if (shift_en) begin
            next_data.uop  = up.uop;
            next_data.rdys = up_rdy_next;
        end else begin
            next_data.uop  = q.uop;
            next_data.rdys = rdy_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q <= '0;
        end else begin
            q <= next_data;
        end
    end

    assign is_store = is_store_op(q.uop.op);

endmodule

// ==== logic/lsu_iq_queue.sv ====
`timescale 1ns/1ns

module lsu_iq_queue import lsu_iq_pkg::*; #(
    parameter int queue_len = 8
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            flush,
    input  logic                            enq0,
    input  logic                            enq1,
    input  lsu_iq_entry_t                   din0,
    input  lsu_iq_entry_t                   din1,
    input  logic                            deq,
    input  logic [$clog2(queue_len)-1:0]    deq_idx,
    input  logic [queue_len+1:0]            busy0,
    input  logic [queue_len+1:0]            busy1,
    output lsu_iq_entry_t [queue_len-1:0]   entries,
    output logic [queue_len-1:0]            valid_vec,
    output logic [queue_len-1:0]            ready_vec,
    output logic [queue_len-1:0]            store_vec,
    output prf_num_t [queue_len+1:0]        rd_num0,
    output prf_num_t [queue_len+1:0]        rd_num1,
    output logic                            full,
    output logic                            ready
);

    localparam int idx_w = $clog2(queue_len);
    localparam int cnt_w = $clog2(queue_len + 1);

    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] tail_d;      // tail after this cycle's dequeue
    logic [cnt_w-1:0] tail_d1;
    logic [cnt_w-1:0] count_next;
    logic             freeze;
    logic             enq0_ok;
    logic             enq1_ok;

    lsu_iq_entry_t             din0_m;
    lsu_iq_entry_t             din1_m;
    lsu_iq_entry_t [queue_len:0] slot_q;
    src_rdy_t [queue_len:0]      slot_rdy_next;

    logic [queue_len-1:0] load_en;
    logic [queue_len-1:0] load_sel;
    logic [queue_len-1:0] shift_en;

    // one slot of headroom so a dual enqueue never overflows
    assign freeze  = count >= cnt_w'(queue_len - 1);
    assign full    = count == cnt_w'(queue_len);
    assign ready   = ~freeze;
    assign enq0_ok = enq0 & ~freeze;
    assign enq1_ok = enq1 & enq0_ok;

    assign tail_d     = count - cnt_w'(deq);
    assign tail_d1    = tail_d + cnt_w'(1);
    assign count_next = tail_d + cnt_w'(enq0_ok) + cnt_w'(enq1_ok);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            count <= '0;
        end else begin
            count <= count_next;
        end
    end

    // incoming lanes pick up not-busy at the enqueue edge
    always_comb begin
        din0_m = din0;
        din1_m = din1;
        din0_m.rdys.rdy0 = din0.rdys.rdy0 | ~busy0[queue_len];
        din0_m.rdys.rdy1 = din0.rdys.rdy1 | ~busy1[queue_len];
        din1_m.rdys.rdy0 = din1.rdys.rdy0 | ~busy0[queue_len+1];
        din1_m.rdys.rdy1 = din1.rdys.rdy1 | ~busy1[queue_len+1];
    end

    assign rd_num0[queue_len]   = din0.uop.psrc0;
    assign rd_num0[queue_len+1] = din1.uop.psrc0;
    assign rd_num1[queue_len]   = din0.uop.psrc1;
    assign rd_num1[queue_len+1] = din1.uop.psrc1;

    // nothing above the top slot
    assign slot_q[queue_len]        = '0;
    assign slot_rdy_next[queue_len] = '0;

    for (genvar i = 0; i < queue_len; i++) begin : g_slot
        assign load_en[i]  = (enq0_ok && tail_d == cnt_w'(i)) ||
                             (enq1_ok && tail_d1 == cnt_w'(i));
        assign load_sel[i] = tail_d != cnt_w'(i);
        assign shift_en[i] = deq && (idx_w'(i) >= deq_idx);

        lsu_iq_entry u_entry (
            .clk         (clk),
            .rst         (rst),
            .flush       (flush),
            .load_en     (load_en[i]),
            .load_sel    (load_sel[i]),
            .shift_en    (shift_en[i]),
            .din0        (din0_m),
            .din1        (din1_m),
            .up          (slot_q[i+1]),
            .up_rdy_next (slot_rdy_next[i+1]),
            .busy0       (busy0[i]),
            .busy1       (busy1[i]),
            .q           (slot_q[i]),
            .rdy_next    (slot_rdy_next[i]),
            .is_store    (store_vec[i])
        );

        assign entries[i]   = slot_q[i];
        assign valid_vec[i] = count > cnt_w'(i);
        assign ready_vec[i] = slot_q[i].rdys.rdy0 & slot_q[i].rdys.rdy1;
        assign rd_num0[i]   = slot_q[i].uop.psrc0;
        assign rd_num1[i]   = slot_q[i].uop.psrc1;
    end

endmodule

// ==== logic/lsu_store_order.sv ====
`timescale 1ns/1ns

module lsu_store_order #(
    parameter int queue_len = 8
) (
    input  logic [queue_len-1:0] valid_vec,
    input  logic [queue_len-1:0] store_vec,
    output logic [queue_len-1:0] order_mask
);

    logic [queue_len-1:0] older_store;

    // prefix OR of valid stores below each slot
    always_comb begin
        older_store[0] = 1'b0;
        for (int i = 1; i < queue_len; i++) begin
            older_store[i] = older_store[i-1] | (valid_vec[i-1] & store_vec[i-1]);
        end
    end

    always_comb begin
        for (int i = 0; i < queue_len; i++) begin
            if (store_vec[i]) begin
                order_mask[i] = (i == 0);   // stores leave from the head only
            end else begin
                order_mask[i] = ~older_store[i];
            end
        end
    end

endmodule

// ==== logic/lsu_issue_select.sv ====
`timescale 1ns/1ns

module lsu_issue_select import lsu_iq_pkg::*; #(
    parameter int queue_len = 8
) (
    input  lsu_iq_entry_t [queue_len-1:0]   entries,
    input  logic [queue_len-1:0]            valid_vec,
    input  logic [queue_len-1:0]            ready_vec,
    input  logic [queue_len-1:0]            order_mask,
    input  logic                            lsu_busy,
    output logic                            issue_fire,
    output logic [$clog2(queue_len)-1:0]    issue_idx,
    output lsu_uop_t                        issue_uop,
    output logic                            issue_valid
);

    localparam int idx_w = $clog2(queue_len);

    logic [queue_len-1:0] cand;

    assign cand = valid_vec & ready_vec & order_mask & {queue_len{~lsu_busy}};

    // lowest index wins, slot 0 is oldest
    always_comb begin
        issue_idx = '0;
        for (int i = queue_len - 1; i >= 0; i--) begin
            if (cand[i]) begin
                issue_idx = idx_w'(i);
            end
        end
    end

    assign issue_fire  = |cand;
    assign issue_valid = issue_fire;

    always_comb begin
        issue_uop       = entries[issue_idx].uop;
        issue_uop.valid = issue_valid;
    end

endmodule

// ==== logic/lsu_issue_unit.sv ====
`timescale 1ns/1ns

module lsu_issue_unit import lsu_iq_pkg::*; #(
    parameter int queue_len = 8
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  logic                        enq0,
    input  logic                        enq1,
    input  lsu_iq_entry_t               din0,
    input  lsu_iq_entry_t               din1,
    input  logic                        lsu_busy,
    input  logic [queue_len+1:0]        busy0,
    input  logic [queue_len+1:0]        busy1,
    output prf_num_t [queue_len+1:0]    rd_num0,
    output prf_num_t [queue_len+1:0]    rd_num1,
    output lsu_uop_t                    issue_uop,
    output logic                        issue_valid,
    output logic                        ready,
    output logic                        full
);

    localparam int idx_w = $clog2(queue_len);

    lsu_iq_entry_t [queue_len-1:0] entries;
    logic [queue_len-1:0]          valid_vec;
    logic [queue_len-1:0]          ready_vec;
    logic [queue_len-1:0]          store_vec;
    logic [queue_len-1:0]          order_mask;
    logic                          issue_fire;
    logic [idx_w-1:0]              issue_idx;

    lsu_iq_queue #(
        .queue_len (queue_len)
    ) u_queue (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .enq0      (enq0),
        .enq1      (enq1),
        .din0      (din0),
        .din1      (din1),
        .deq       (issue_fire),   // issued slot leaves at this edge
        .deq_idx   (issue_idx),
        .busy0     (busy0),
        .busy1     (busy1),
        .entries   (entries),
        .valid_vec (valid_vec),
        .ready_vec (ready_vec),
        .store_vec (store_vec),
        .rd_num0   (rd_num0),
        .rd_num1   (rd_num1),
        .full      (full),
        .ready     (ready)
    );

    lsu_store_order #(
        .queue_len (queue_len)
    ) u_order (
        .valid_vec  (valid_vec),
        .store_vec  (store_vec),
        .order_mask (order_mask)
    );

    lsu_issue_select #(
        .queue_len (queue_len)
    ) u_select (
        .entries     (entries),
        .valid_vec   (valid_vec),
        .ready_vec   (ready_vec),
        .order_mask  (order_mask),
        .lsu_busy    (lsu_busy),
        .issue_fire  (issue_fire),
        .issue_idx   (issue_idx),
        .issue_uop   (issue_uop),
        .issue_valid (issue_valid)
    );

endmodule

// ==== verif/lsu_issue_unit_assert.sv ====
`timescale 1ns/1ns

module lsu_issue_unit_assert import lsu_iq_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     flush,
    input logic     issue_valid,
    input lsu_uop_t issue_uop,
    input logic     ready,
    input logic     full
);

    // reset held across a whole cycle
    no_issue_in_reset: assert property (
        @(posedge clk) rst && $past(rst) |-> !issue_valid
    ) else $error("issue_valid high while reset is held");

    full_not_ready: assert property (
        @(posedge clk) full |-> !ready
    ) else $error("full and ready both high");

    issue_carries_valid: assert property (
        @(posedge clk) issue_valid |-> issue_uop.valid
    ) else $error("issue_valid without issue_uop.valid");

    // queue is empty the cycle after a flush
    empty_after_flush: assert property (
        @(posedge clk) $past(flush) |-> !issue_valid
    ) else $error("issue right after flush");

endmodule

bind lsu_issue_unit lsu_issue_unit_assert u_assert (
    .clk         (clk),
    .rst         (rst),
    .flush       (flush),
    .issue_valid (issue_valid),
    .issue_uop   (issue_uop),
    .ready       (ready),
    .full        (full)
);

// ==== verif/tb_lsu_issue_unit.sv ====
`timescale 1ns/1ns

module tb_lsu_issue_unit import lsu_iq_pkg::*; ();

    localparam int queue_len  = 8;
    localparam int clk_period = 100;
    localparam int rst_cycles = 4;
    localparam int num_rows   = 43;
    localparam int timeout_ns = (num_rows + rst_cycles + 20) * clk_period;
    localparam logic [63:0] no_busy = '0;

    typedef struct packed {
        logic [7:0]    test_id;
        logic          enq0;
        logic          enq1;
        lsu_iq_entry_t din0;
        lsu_iq_entry_t din1;
        logic          lsu_busy;
        logic          flush;
        logic [63:0]   busy_set;   // one bit per physical register
        logic          exp_valid;
        logic [5:0]    exp_tag;
        logic          chk_ready;
        logic          exp_ready;
        logic          exp_full;
    } row_t;

    logic clk;
    logic rst;
    logic flush;
    logic enq0;
    logic enq1;
    lsu_iq_entry_t din0;
    lsu_iq_entry_t din1;
    logic lsu_busy;
    logic [queue_len+1:0] busy0;
    logic [queue_len+1:0] busy1;
    prf_num_t [queue_len+1:0] rd_num0;
    prf_num_t [queue_len+1:0] rd_num1;
    lsu_uop_t issue_uop;
    logic issue_valid;
    logic ready;
    logic full;
    logic [63:0] busy_set;

    row_t rows [num_rows];
    int row_cnt;
    integer seed;
    int err_cnt;
    int test_err;
    int tests_passed;
    int tests_failed;

    // expected issue bundle, by rob tag
    lsu_uop_t tag_uop [64];

    lsu_issue_unit #(
        .queue_len (queue_len)
    ) dut0 (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .enq0        (enq0),
        .enq1        (enq1),
        .din0        (din0),
        .din1        (din1),
        .lsu_busy    (lsu_busy),
        .busy0       (busy0),
        .busy1       (busy1),
        .rd_num0     (rd_num0),
        .rd_num1     (rd_num1),
        .issue_uop   (issue_uop),
        .issue_valid (issue_valid),
        .ready       (ready),
        .full        (full)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    // scoreboard model, answers every lookup port
    always_comb begin
        for (int i = 0; i < queue_len + 2; i++) begin
            busy0[i] = busy_set[rd_num0[i]];
            busy1[i] = busy_set[rd_num1[i]];
        end
    end

    function automatic logic [63:0] reg_bit(input int n);
        return 64'd1 << n;
    endfunction

    function automatic lsu_iq_entry_t fill_uop(input mem_op_e op, input int tag,
                                               input int base, input int data);
        lsu_iq_entry_t e;
        logic [31:0] rnd;
        rnd = $random(seed);
        e = '0;
        e.uop.valid   = 1'b1;
        e.uop.op      = op;
        e.uop.psrc0   = base[5:0];
        e.uop.psrc1   = data[5:0];
        e.uop.pdest   = rnd[5:0];
        e.uop.imm     = rnd[17:6];
        e.uop.rob_tag = tag[5:0];
        tag_uop[tag[5:0]] = e.uop;
        return e;
    endfunction

    function automatic lsu_iq_entry_t make_load(input int tag, input int base);
        lsu_iq_entry_t e;
        e = fill_uop(op_lw, tag, base, 0);
        e.rdys.rdy1 = 1'b1;     // no data source
        return e;
    endfunction

    function automatic lsu_iq_entry_t make_store(input int tag, input int base, input int data);
        return fill_uop(op_sw, tag, base, data);
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1:       return "program order";
            2:       return "wakeup";
            3:       return "store ordering";
            4:       return "unit busy";
            5:       return "capacity";
            default: return "flush";
        endcase
    endfunction

    task automatic add_row(input int id, input int e0, input int e1,
                           input lsu_iq_entry_t d0, input lsu_iq_entry_t d1,
                           input int lb, input int fl, input logic [63:0] bset,
                           input int ev, input int etag, input int cr, input int er,
                           input int ef = 0);
        row_t r;
        r.test_id   = id[7:0];
        r.enq0      = (e0 != 0);
        r.enq1      = (e1 != 0);
        r.din0      = d0;
        r.din1      = d1;
        r.lsu_busy  = (lb != 0);
        r.flush     = (fl != 0);
        r.busy_set  = bset;
        r.exp_valid = (ev != 0);
        r.exp_tag   = etag[5:0];
        r.chk_ready = (cr != 0);
        r.exp_ready = (er != 0);
        r.exp_full  = (ef != 0);
        if (row_cnt < num_rows) begin
            rows[row_cnt] = r;
        end
        row_cnt++;
    endtask

    task automatic build_table();
        lsu_iq_entry_t nil;
        logic [63:0] b20;
        logic [63:0] b30;
        nil = '0;
        b20 = reg_bit(20);
        b30 = reg_bit(30);
        // id e0 e1 din0 din1 lsu_busy flush busy_set exp_valid exp_tag chk_ready exp_ready
        // exp_full as an optional last column
        add_row(1, 1, 1, make_load(1, 1), make_load(2, 2), 0, 0, no_busy, 0, 0, 1, 1);
        add_row(1, 1, 0, make_load(3, 3), nil, 0, 0, no_busy, 1, 1, 1, 1);
        add_row(1, 0, 0, nil, nil, 0, 0, no_busy, 1, 2, 0, 0);
        add_row(1, 0, 0, nil, nil, 0, 0, no_busy, 1, 3, 0, 0);
        add_row(1, 0, 0, nil, nil, 0, 0, no_busy, 0, 0, 1, 1);
        // load 10 waits on p20
        add_row(2, 1, 1, make_load(10, 20), make_load(11, 21), 0, 0, b20, 0, 0, 0, 0);
        add_row(2, 1, 0, make_load(12, 22), nil, 0, 0, b20, 1, 11, 0, 0);
        add_row(2, 0, 0, nil, nil, 0, 0, b20, 1, 12, 0, 0);
        add_row(2, 0, 0, nil, nil, 0, 0, no_busy, 0, 0, 0, 0);
        add_row(2, 0, 0, nil, nil, 0, 0, no_busy, 1, 10, 0, 0);
        // store 21 sits between a blocked load and a ready one
        add_row(3, 1, 1, make_load(20, 30), make_store(21, 31, 32), 0, 0, b30, 0, 0, 0, 0);
        add_row(3, 1, 0, make_load(22, 33), nil, 0, 0, b30, 0, 0, 0, 0);
        add_row(3, 0, 0, nil, nil, 0, 0, b30, 0, 0, 0, 0);
        add_row(3, 0, 0, nil, nil, 0, 0, no_busy, 0, 0, 0, 0);
        add_row(3, 0, 0, nil, nil, 0, 0, no_busy, 1, 20, 0, 0);
        add_row(3, 0, 0, nil, nil, 0, 0, no_busy, 1, 21, 0, 0);
        add_row(3, 0, 0, nil, nil, 0, 0, no_busy, 1, 22, 0, 0);
        add_row(3, 0, 0, nil, nil, 0, 0, no_busy, 0, 0, 0, 0);
        add_row(4, 1, 1, make_load(40, 40), make_load(41, 41), 0, 0, no_busy, 0, 0, 0, 0);
        add_row(4, 0, 0, nil, nil, 1, 0, no_busy, 0, 0, 0, 0);
        add_row(4, 1, 0, make_load(42, 42), nil, 1, 0, no_busy, 0, 0, 0, 0);
        add_row(4, 0, 0, nil, nil, 0, 0, no_busy, 1, 40, 0, 0);
        add_row(4, 0, 0, nil, nil, 0, 0, no_busy, 1, 41, 0, 0);
        add_row(4, 0, 0, nil, nil, 0, 0, no_busy, 1, 42, 0, 0);
        add_row(4, 0, 0, nil, nil, 0, 0, no_busy, 0, 0, 0, 0);
        // fill all eight, then enqueues at eight and seven that must be dropped
        add_row(5, 1, 1, make_load(50, 50), make_load(51, 51), 1, 0, no_busy, 0, 0, 1, 1);
        add_row(5, 1, 1, make_load(52, 52), make_load(53, 53), 1, 0, no_busy, 0, 0, 1, 1);
        add_row(5, 1, 1, make_load(54, 54), make_load(55, 55), 1, 0, no_busy, 0, 0, 1, 1);
        add_row(5, 1, 1, make_load(56, 56), make_load(57, 57), 1, 0, no_busy, 0, 0, 1, 1);
        add_row(5, 1, 0, make_load(58, 58), nil, 1, 0, no_busy, 0, 0, 1, 0, 1);
        add_row(5, 0, 0, nil, nil, 0, 0, no_busy, 1, 50, 1, 0, 1);
        add_row(5, 1, 0, make_load(59, 59), nil, 0, 0, no_busy, 1, 51, 1, 0);
        add_row(5, 0, 0, nil, nil, 0, 0, no_busy, 1, 52, 1, 1);
        add_row(5, 0, 0, nil, nil, 0, 0, no_busy, 1, 53, 0, 0);
        add_row(5, 0, 0, nil, nil, 0, 0, no_busy, 1, 54, 0, 0);
        add_row(5, 0, 0, nil, nil, 0, 0, no_busy, 1, 55, 0, 0);
        add_row(5, 0, 0, nil, nil, 0, 0, no_busy, 1, 56, 0, 0);
        add_row(5, 0, 0, nil, nil, 0, 0, no_busy, 1, 57, 0, 0);
        add_row(5, 0, 0, nil, nil, 0, 0, no_busy, 0, 0, 1, 1);
        add_row(6, 1, 1, make_load(60, 60), make_load(61, 61), 1, 0, no_busy, 0, 0, 0, 0);
        add_row(6, 0, 0, nil, nil, 1, 1, no_busy, 0, 0, 0, 0);
        add_row(6, 0, 0, nil, nil, 0, 0, no_busy, 0, 0, 1, 1);
        add_row(6, 0, 0, nil, nil, 0, 0, no_busy, 0, 0, 1, 1);
    endtask

    task automatic apply_row(input row_t w);
        enq0     = w.enq0;
        enq1     = w.enq1;
        din0     = w.din0;
        din1     = w.din1;
        lsu_busy = w.lsu_busy;
        flush    = w.flush;
        busy_set = w.busy_set;
    endtask

    task automatic count_error();
        err_cnt++;
        test_err++;
    endtask

    task automatic check_row(input int r);
        row_t w;
        w = rows[r];
        if (issue_valid !== w.exp_valid) begin
            $display("[FAIL] test %0d row %0d: issue_valid expected %h got %h",
                     w.test_id, r, w.exp_valid, issue_valid);
            count_error();
        end else if (w.exp_valid) begin
            if (issue_uop.rob_tag !== w.exp_tag) begin
                $display("[FAIL] test %0d row %0d: issue_uop.rob_tag expected %h got %h",
                         w.test_id, r, w.exp_tag, issue_uop.rob_tag);
                count_error();
            end else if (issue_uop !== tag_uop[w.exp_tag]) begin
                $display("[FAIL] test %0d row %0d: issue_uop expected %h got %h",
                         w.test_id, r, tag_uop[w.exp_tag], issue_uop);
                count_error();
            end
        end
        if (w.chk_ready && ready !== w.exp_ready) begin
            $display("[FAIL] test %0d row %0d: ready expected %h got %h",
                     w.test_id, r, w.exp_ready, ready);
            count_error();
        end
        if (full !== w.exp_full) begin
            $display("[FAIL] test %0d row %0d: full expected %h got %h",
                     w.test_id, r, w.exp_full, full);
            count_error();
        end
    endtask

    task automatic report_test(input int id);
        if (test_err == 0) begin
            tests_passed++;
            $display("test %0d (%s): ok", id, test_name(id));
        end else begin
            tests_failed++;
            $display("test %0d (%s): %0d check errors", id, test_name(id), test_err);
        end
        test_err = 0;
    endtask

    initial begin
        #(timeout_ns);
        $display("watchdog: run did not finish within %0d ns", timeout_ns);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        seed         = 12702;
        row_cnt      = 0;
        err_cnt      = 0;
        test_err     = 0;
        tests_passed = 0;
        tests_failed = 0;
        rst      = 1'b1;
        flush    = 1'b0;
        enq0     = 1'b0;
        enq1     = 1'b0;
        din0     = '0;
        din1     = '0;
        lsu_busy = 1'b0;
        busy_set = '0;
        build_table();
        if (row_cnt != num_rows) begin
            $display("stimulus table holds %0d rows, %0d expected", row_cnt, num_rows);
            err_cnt++;
        end
        repeat (rst_cycles) @(posedge clk);
        #10;
        rst = 1'b0;
        for (int r = 0; r < num_rows; r++) begin
            apply_row(rows[r]);
            #80;    // just ahead of the next edge
            check_row(r);
            if (r == num_rows - 1) begin
                report_test(int'(rows[r].test_id));
            end else if (rows[r + 1].test_id != rows[r].test_id) begin
                report_test(int'(rows[r].test_id));
            end
            @(posedge clk);
            #10;
        end
        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_passed, tests_failed, err_cnt);
        if (err_cnt == 0 && tests_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
logic/lsu_iq_pkg.sv
logic/lsu_iq_entry.sv
logic/lsu_iq_queue.sv
logic/lsu_store_order.sv
logic/lsu_issue_select.sv
logic/lsu_issue_unit.sv
verif/lsu_issue_unit_assert.sv
verif/tb_lsu_issue_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_lsu_issue_unit \
    -f src.f -o tb_sim \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Simulation PASSED" && exit 0 || exit 1
